// ==== hdl/cache_pkg.sv ====
package cache_pkg;

  // ---------------------------------------------------------------------
  // Address fields
  // ---------------------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [1:0]  way_t;

  localparam int num_ways = 4;

  // Set index, address bits 10..6
  localparam int set_bits = 5;
  typedef logic [set_bits-1:0] set_t;

  // Set plus word within the line, address bits 10..2
  localparam int word_index_bits = 9;
  typedef logic [word_index_bits-1:0] word_index_t;

  // Tag, address bits 31..11
  localparam int tag_bits = 21;
  typedef logic [tag_bits-1:0] tag_t;

  // Top nibble 4'hF is the IO region
  localparam addr_t io_base = 32'hF000_0000;
  localparam addr_t io_mask = 32'hF000_0000;

  // ---------------------------------------------------------------------
  // Bundles
  // ---------------------------------------------------------------------
  typedef struct packed {
    addr_t    address;
    byte_en_t byte_en;
    logic     read;
    logic     write;
    word_t    write_data;
  } cache_req_t;

  typedef struct packed {
    logic hit;
    way_t hit_way;
    logic has_free;
    way_t free_way;
  } lookup_t;

  typedef struct packed {
    logic     tag_we;
    logic     data_we;
    way_t     way;
    addr_t    address;
    word_t    data;
    byte_en_t byte_en;
  } fill_t;

  typedef enum logic [1:0] {
    cmd_nop          = 2'd0,
    cmd_refill_block = 2'd1,
    cmd_io_rw        = 2'd2
  } refill_cmd_e;

  function automatic set_t addr_set(addr_t a);
    return a[6 +: set_bits];
  endfunction

  function automatic word_index_t addr_word(addr_t a);
    return a[2 +: word_index_bits];
  endfunction

  function automatic tag_t addr_tag(addr_t a);
    return a[31 -: tag_bits];
  endfunction

endpackage

// ==== hdl/cache_tag_ram.sv ====
`timescale 1ns/1ps

module cache_tag_ram (
  input  logic              clk,
  input  logic              rest,
  input  cache_pkg::set_t    read_set,
  input  cache_pkg::tag_t    compare_tag,
  input  cache_pkg::fill_t   fill,
  input  logic              fill_en,
  output cache_pkg::lookup_t lookup
);
  import cache_pkg::*;

  tag_t                tags  [num_ways][2**set_bits];
  logic [num_ways-1:0] valid [2**set_bits];

  tag_t                rd_tags [num_ways];
  logic [num_ways-1:0] rd_valid;

  // ---------------------------------------------------------------------
  // Tag storage
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (fill_en && fill.tag_we) begin
      tags[fill.way][addr_set(fill.address)] <= addr_tag(fill.address);
    end
    for (int w = 0; w < num_ways; w++) begin
      rd_tags[w] <= tags[w][read_set];
    end
  end

  // Valid bits clear on reset
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int s = 0; s < 2**set_bits; s++) begin
        valid[s] <= '0;
      end
      rd_valid <= '0;
    end else begin
      if (fill_en && fill.tag_we) begin
        valid[addr_set(fill.address)][fill.way] <= 1'b1;
      end
      rd_valid <= valid[read_set];
    end
  end

  // ---------------------------------------------------------------------
  // Compare against the held tag
  // ---------------------------------------------------------------------
  always_comb begin
    lookup = '0;
    // Walk downwards so the lowest way wins
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (rd_valid[w] && rd_tags[w] == compare_tag) begin
        lookup.hit     = 1'b1;
        lookup.hit_way = way_t'(w);
      end
      if (!rd_valid[w]) begin
        lookup.has_free = 1'b1;
        lookup.free_way = way_t'(w);
      end
    end
  end

endmodule

// ==== hdl/cache_data_ram.sv ====
`timescale 1ns/1ps

module cache_data_ram (
  input  logic                   clk,
  input  cache_pkg::word_index_t read_index,
  input  cache_pkg::way_t        read_way,
  output cache_pkg::word_t       read_data,
  input  logic                   write_en,
  input  cache_pkg::way_t        write_way,
  input  cache_pkg::word_index_t write_index,
  input  cache_pkg::byte_en_t    write_byte_en,
  input  cache_pkg::word_t       write_data
);
  import cache_pkg::*;

  word_t mem      [num_ways][2**word_index_bits];
  word_t rd_words [num_ways];

  // Byte-enabled write
  always_ff @(posedge clk) begin
    if (write_en) begin
      for (int b = 0; b < 4; b++) begin
        if (write_byte_en[b]) begin
          mem[write_way][write_index][b*8 +: 8] <= write_data[b*8 +: 8];
        end
      end
    end
  end

  // All four ways read at once, way picked later
  always_ff @(posedge clk) begin
    for (int w = 0; w < num_ways; w++) begin
      rd_words[w] <= mem[w][read_index];
    end
  end

  // Hit way only known after the tag register
  assign read_data = rd_words[read_way];

endmodule

// ==== hdl/cache_readable_ram.sv ====
`timescale 1ns/1ps

module cache_readable_ram (
  input  logic                   clk,
  input  logic                   rest,
  input  cache_pkg::word_index_t read_index,
  input  cache_pkg::way_t        read_way,
  output cache_pkg::byte_en_t    readable,
  input  logic                   write_en,
  input  cache_pkg::way_t        write_way,
  input  cache_pkg::word_index_t write_index,
  input  cache_pkg::byte_en_t    set_bytes
);
  import cache_pkg::*;

  byte_en_t bits    [num_ways][2**word_index_bits];
  byte_en_t rd_bits [num_ways];

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int w = 0; w < num_ways; w++) begin
        for (int i = 0; i < 2**word_index_bits; i++) begin
          bits[w][i] <= '0;
        end
        rd_bits[w] <= '0;
      end
    end else begin
      // Bits only ever get set until the next reset
      if (write_en) begin
        bits[write_way][write_index] <= bits[write_way][write_index] | set_bytes;
      end
      for (int w = 0; w < num_ways; w++) begin
        rd_bits[w] <= bits[w][read_index];
      end
    end
  end

  assign readable = rd_bits[read_way];

endmodule

// ==== hdl/cache_cmd_fsm.sv ====
`timescale 1ns/1ps

module cache_cmd_fsm (
  input  logic                   clk,
  input  logic                   rest,
  input  logic                   fault,
  input  logic                   io_addr,
  input  logic                   cmd_ready,
  output cache_pkg::refill_cmd_e cmd,
  output logic                   recovering
);
  import cache_pkg::*;

  typedef enum logic {
    st_idle,
    st_wait_done
  } state_e;

  state_e state;

  // ---------------------------------------------------------------------
  // Command issue and hold
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state      <= st_idle;
      cmd        <= cmd_nop;
      recovering <= 1'b0;
    end else begin
      recovering <= 1'b0;
      case (state)
        st_idle: begin
          if (fault) begin
            cmd   <= io_addr ? cmd_io_rw : cmd_refill_block;
            state <= st_wait_done;
          end
        end
        st_wait_done: begin
          // Refill engine owns the RAMs until its strobe
          if (cmd_ready) begin
            cmd        <= cmd_nop;
            state      <= st_idle;
            recovering <= 1'b1;
          end
        end
        default: begin
          cmd   <= cmd_nop;
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

// ==== hdl/cache_rw.sv ====
`timescale 1ns/1ps

module cache_rw (
  input  logic                   clk,
  input  logic                   rest,
  input  cache_pkg::cache_req_t  req,
  output logic                   wait_request,
  output cache_pkg::word_t       read_data,
  output logic                   read_data_valid,
  output cache_pkg::refill_cmd_e ri_cmd,
  output cache_pkg::cache_req_t  ri_req,
  output cache_pkg::lookup_t     ri_lookup,
  input  logic                   ri_cmd_ready,
  input  cache_pkg::word_t       ri_rsp_data,
  input  cache_pkg::fill_t       fill
);
  import cache_pkg::*;

  cache_req_t held_req;
  cache_req_t fwd_req;
  lookup_t    lookup;
  lookup_t    lookup_q;
  fill_t      ram_wr;

  word_t    ram_data;
  word_t    merged_data;
  byte_en_t ram_readable;
  byte_en_t readable;

  logic recovering;
  logic fill_en;
  logic io_addr;
  logic fwd_hit;
  logic read_fault;
  logic write_fault;
  logic fault;
  logic write_hit;

  // ---------------------------------------------------------------------
  // Request and forward stages
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      held_req <= '0;
      fwd_req  <= '0;
      lookup_q <= '0;
    end else begin
      if (!wait_request) begin
        held_req <= req;
        fwd_req  <= held_req;
      end
      // Freeze the lookup once the refill engine takes over
      if (!fill_en) begin
        lookup_q <= lookup;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Forwarding and fault detection
  // ---------------------------------------------------------------------
  assign fill_en = (ri_cmd != cmd_nop);
  assign io_addr = ((held_req.address & io_mask) == io_base);
  assign fwd_hit = fwd_req.write && (fwd_req.address[31:2] == held_req.address[31:2]);

  // Bytes of the previous write override the RAM word
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      if (fwd_hit && fwd_req.byte_en[b]) begin
        merged_data[b*8 +: 8] = fwd_req.write_data[b*8 +: 8];
      end else begin
        merged_data[b*8 +: 8] = ram_data[b*8 +: 8];
      end
    end
  end

  assign readable = ram_readable | (fwd_hit ? fwd_req.byte_en : byte_en_t'(0));

  assign read_fault = held_req.read &&
                      (io_addr || !lookup.hit ||
                       ((readable & held_req.byte_en) != held_req.byte_en));
  assign write_fault = held_req.write && (io_addr || !lookup.hit);

  // Held request was already served during recovery
  assign fault     = (read_fault || write_fault) && !recovering;
  assign write_hit = held_req.write && !write_fault && !recovering && !fill_en;

  assign wait_request    = fault || fill_en;
  assign read_data       = fill_en ? ri_rsp_data : merged_data;
  assign read_data_valid = held_req.read &&
                           (fill_en ? ri_cmd_ready : (!read_fault && !recovering));

  assign ri_req    = held_req;
  assign ri_lookup = lookup_q;

  // ---------------------------------------------------------------------
  // RAM write ownership
  // ---------------------------------------------------------------------
  always_comb begin
    if (fill_en) begin
      ram_wr = fill;
    end else begin
      ram_wr.tag_we  = 1'b0;
      ram_wr.data_we = write_hit;
      ram_wr.way     = lookup.hit_way;
      ram_wr.address = held_req.address;
      ram_wr.data    = held_req.write_data;
      ram_wr.byte_en = held_req.byte_en;
    end
  end

  cache_tag_ram tag_ram_inst (
    .clk         (clk),
    .rest        (rest),
    .read_set    (addr_set(req.address)),
    .compare_tag (addr_tag(held_req.address)),
    .fill        (ram_wr),
    .fill_en     (fill_en),
    .lookup      (lookup)
  );

  cache_data_ram data_ram_inst (
    .clk           (clk),
    .read_index    (addr_word(req.address)),
    .read_way      (lookup.hit_way),
    .read_data     (ram_data),
    .write_en      (ram_wr.data_we),
    .write_way     (ram_wr.way),
    .write_index   (addr_word(ram_wr.address)),
    .write_byte_en (ram_wr.byte_en),
    .write_data    (ram_wr.data)
  );

  cache_readable_ram readable_ram_inst (
    .clk         (clk),
    .rest        (rest),
    .read_index  (addr_word(req.address)),
    .read_way    (lookup.hit_way),
    .readable    (ram_readable),
    .write_en    (ram_wr.data_we),
    .write_way   (ram_wr.way),
    .write_index (addr_word(ram_wr.address)),
    .set_bytes   (ram_wr.byte_en)
  );

  cache_cmd_fsm cmd_fsm_inst (
    .clk        (clk),
    .rest       (rest),
    .fault      (fault),
    .io_addr    (io_addr),
    .cmd_ready  (ri_cmd_ready),
    .cmd        (ri_cmd),
    .recovering (recovering)
  );

endmodule

// ==== bench/cache_rw_clock.sv ====
`timescale 1ns/1ps

module cache_rw_clock (
  output logic clk
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule

// ==== bench/cache_rw_tb.sv ====
`timescale 1ns/1ps

module cache_rw_tb;
  import cache_pkg::*;

  localparam int timeout_cycles = 2000;

  // Expected outcome of a request
  localparam int k_idle   = 0;
  localparam int k_hit    = 1;
  localparam int k_miss   = 2;
  localparam int k_unread = 3;
  localparam int k_io     = 4;

  logic        clk;
  logic        rest;
  cache_req_t  req;
  logic        wait_request;
  word_t       read_data;
  logic        read_data_valid;
  refill_cmd_e ri_cmd;
  cache_req_t  ri_req;
  lookup_t     ri_lookup;
  logic        ri_cmd_ready;
  word_t       ri_rsp_data;
  fill_t       fill;

  // Backing memory and IO device, keyed by word address
  word_t mem_model [logic [29:0]];
  word_t io_model  [logic [29:0]];

  // Expectation for the request on the bus
  int    cur_kind;
  word_t cur_exp;
  word_t cur_mask;
  string cur_name;

  // Same, for the request the DUT holds
  int          m_kind;
  word_t       m_exp;
  word_t       m_mask;
  string       m_name;
  cache_req_t  m_req;
  logic        m_first;
  refill_cmd_e m_cmd;

  int    errors;
  int    n_requests;
  int    cycles;
  addr_t way_addr [num_ways];

  cache_rw_clock clock_inst (.clk(clk));

  cache_rw cache_rw_inst (
    .clk             (clk),
    .rest            (rest),
    .req             (req),
    .wait_request    (wait_request),
    .read_data       (read_data),
    .read_data_valid (read_data_valid),
    .ri_cmd          (ri_cmd),
    .ri_req          (ri_req),
    .ri_lookup       (ri_lookup),
    .ri_cmd_ready    (ri_cmd_ready),
    .ri_rsp_data     (ri_rsp_data),
    .fill            (fill)
  );

  function automatic word_t byte_mask(byte_en_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  function automatic word_t merge_bytes(word_t old_word, word_t new_word, byte_en_t be);
    word_t mask;
    mask = byte_mask(be);
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // Untouched words get a pattern from their address
  function automatic word_t mem_word(addr_t a);
    if (mem_model.exists(a[31:2])) begin
      return mem_model[a[31:2]];
    end
    return {a[31:2], 2'b00} ^ 32'h9e37_79b9;
  endfunction

  function automatic word_t io_word(addr_t a);
    if (io_model.exists(a[31:2])) begin
      return io_model[a[31:2]];
    end
    return {a[15:2], a[31:16], 2'b01} ^ 32'h0f1e_2d3c;
  endfunction

  // ---------------------------------------------------------------------
  // Refill engine model
  // ---------------------------------------------------------------------
  task automatic answer_command();
    addr_t a;
    way_t  way;
    int    delay;
    delay = int'($urandom % 4) + 1;
    repeat (delay) @(negedge clk);
    a    = ri_req.address;
    fill = '0;
    if (ri_cmd == cmd_io_rw) begin
      if (ri_req.write) begin
        io_model[a[31:2]] = merge_bytes(io_word(a), ri_req.write_data, ri_req.byte_en);
        ri_rsp_data = '0;
      end else begin
        ri_rsp_data = io_word(a);
      end
    end else begin
      // Line already present keeps its way
      way = ri_lookup.has_free ? ri_lookup.free_way : way_t'(0);
      if (ri_lookup.hit) begin
        way = ri_lookup.hit_way;
      end
      ri_rsp_data  = mem_word(a);
      fill.tag_we  = 1'b1;
      fill.data_we = 1'b1;
      fill.way     = way;
      fill.address = a;
      fill.data    = ri_rsp_data;
      fill.byte_en = 4'hF;
    end
    ri_cmd_ready = 1'b1;
    @(negedge clk);
    ri_cmd_ready = 1'b0;
    fill         = '0;
  endtask

  initial begin
    ri_cmd_ready = 1'b0;
    ri_rsp_data  = '0;
    fill         = '0;
    forever begin
      @(negedge clk);
      if (rest && ri_cmd != cmd_nop) begin
        answer_command();
      end
    end
  end

  // ---------------------------------------------------------------------
  // Bus side
  // ---------------------------------------------------------------------
  task automatic drive_idle(input int n);
    req      = '0;
    cur_kind = k_idle;
    cur_exp  = '0;
    cur_mask = '0;
    cur_name = "idle";
    repeat (n) @(negedge clk);
  endtask

  // Returns in the cycle after a hit, or in the recovery cycle after a fault
  task automatic issue_request(input int kind, input addr_t addr, input logic is_write,
                               input byte_en_t be, input word_t data, input string name);
    cache_req_t r;
    logic       io;
    r.address    = addr;
    r.byte_en    = be;
    r.read       = !is_write;
    r.write      = is_write;
    r.write_data = data;
    io           = (addr[31:28] == 4'hF);
    cur_kind     = kind;
    cur_name     = name;
    cur_mask     = byte_mask(be);
    cur_exp      = io ? io_word(addr) : mem_word(addr);
    if (is_write && !io) begin
      mem_model[addr[31:2]] = merge_bytes(mem_word(addr), data, be);
    end
    req = r;
    n_requests++;
    while (wait_request) @(negedge clk);
    @(negedge clk);
    if (kind != k_hit) begin
      while (ri_cmd == cmd_nop) @(negedge clk);
      while (ri_cmd != cmd_nop) @(negedge clk);
    end
  endtask

  // Four tags in one set, then hits in random order
  task automatic fill_and_reread_set();
    tag_t tag;
    int   order [num_ways];
    int   j;
    int   tmp;
    for (int i = 0; i < num_ways; i++) begin
      tag         = {1'b0, 18'($urandom), 2'(i)};
      way_addr[i] = {tag, 5'd5, 4'd3, 2'b00};
      issue_request(k_miss, way_addr[i], 1'b0, 4'hF, '0, "set_fill");
    end
    for (int i = 0; i < num_ways; i++) begin
      order[i] = i;
    end
    // Shuffle so every way is read back once
    for (int i = num_ways - 1; i > 0; i--) begin
      j        = int'($urandom % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < num_ways; i++) begin
      issue_request(k_hit, way_addr[order[i]], 1'b0, 4'hF, '0, "set_reread");
    end
  endtask

  // Mirror of the DUT's request register
  always @(posedge clk or negedge rest) begin
    if (!rest) begin
      m_kind  <= k_idle;
      m_exp   <= '0;
      m_mask  <= '0;
      m_name  <= "idle";
      m_req   <= '0;
      m_first <= 1'b0;
    end else if (!wait_request) begin
      m_kind  <= cur_kind;
      m_exp   <= cur_exp;
      m_mask  <= cur_mask;
      m_name  <= cur_name;
      m_req   <= req;
      m_first <= 1'b1;
    end else begin
      m_first <= 1'b0;
    end
  end

  // Hits and idle cycles expect no command at all
  assign m_cmd = (m_kind == k_io)   ? cmd_io_rw :
                 (m_kind >= k_miss) ? cmd_refill_block : cmd_nop;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: run still busy after %0d cycles, %0d errors", cycles, errors);
      $display("Testbench failed");
      $finish;
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  reset_idle: assert property (@(posedge clk)
    !rest |-> !wait_request && !read_data_valid && ri_cmd == cmd_nop)
  else begin
    errors++;
    $display("Outputs not idle during reset at %0t", $time);
  end

  read_data_ok: assert property (@(posedge clk) disable iff (!rest)
    read_data_valid |-> (read_data & m_mask) == (m_exp & m_mask))
  else begin
    errors++;
    $display("CHECK FAILED %s: read_data expected %h, actual %h",
             m_name, m_exp & m_mask, read_data & m_mask);
  end

  valid_is_read: assert property (@(posedge clk) disable iff (!rest)
    read_data_valid |-> m_kind != k_idle && m_req.read)
  else begin
    errors++;
    $display("read_data_valid raised for a request that is not a read (%s)", m_name);
  end

  hit_in_one_cycle: assert property (@(posedge clk) disable iff (!rest)
    m_first && m_kind == k_hit |-> !wait_request && read_data_valid == m_req.read)
  else begin
    errors++;
    $display("Hit %s did not complete one cycle after acceptance", m_name);
  end

  fault_waits: assert property (@(posedge clk) disable iff (!rest)
    m_first && m_kind >= k_miss |-> wait_request)
  else begin
    errors++;
    $display("Fault %s did not raise wait_request", m_name);
  end

  cmd_kind_ok: assert property (@(posedge clk) disable iff (!rest)
    ri_cmd != cmd_nop |-> ri_cmd == m_cmd)
  else begin
    errors++;
    $display("CHECK FAILED %s: ri_cmd expected %0d, actual %0d", m_name, m_cmd, ri_cmd);
  end

  cmd_req_ok: assert property (@(posedge clk) disable iff (!rest)
    ri_cmd != cmd_nop |-> ri_req == m_req)
  else begin
    errors++;
    $display("CHECK FAILED %s: ri_req expected %h, actual %h", m_name, m_req, ri_req);
  end

  lookup_hit_ok: assert property (@(posedge clk) disable iff (!rest)
    ri_cmd != cmd_nop && (m_kind == k_miss || m_kind == k_unread)
      |-> ri_lookup.hit == (m_kind == k_unread))
  else begin
    errors++;
    $display("CHECK FAILED %s: ri_lookup.hit expected %0b, actual %0b",
             m_name, m_kind == k_unread, ri_lookup.hit);
  end

  faulted_read_done: assert property (@(posedge clk) disable iff (!rest)
    ri_cmd != cmd_nop && ri_cmd_ready |-> read_data_valid == m_req.read)
  else begin
    errors++;
    $display("Refill response for %s not returned with read_data_valid", m_name);
  end

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  initial begin
    void'($urandom(32'h6b26_c1c7));
    errors     = 0;
    n_requests = 0;
    cycles     = 0;
    rest       = 1'b0;
    req        = '0;
    cur_kind   = k_idle;
    cur_exp    = '0;
    cur_mask   = '0;
    cur_name   = "idle";
    repeat (2) @(posedge clk);
    @(negedge clk);
    rest = 1'b1;
    drive_idle(2);

    issue_request(k_miss, 32'h0000_0040, 1'b0, 4'hF, '0, "read_miss");
    issue_request(k_hit, 32'h0000_0040, 1'b0, 4'hF, '0, "read_hit");
    // Line present, neighbour word not yet readable
    issue_request(k_unread, 32'h0000_0044, 1'b0, 4'hF, '0, "read_unreadable");
    issue_request(k_hit, 32'h0000_0044, 1'b0, 4'hF, '0, "read_refilled");

    issue_request(k_hit, 32'h0000_0040, 1'b1, 4'b0110, $urandom, "write_hit");
    issue_request(k_hit, 32'h0000_0040, 1'b0, 4'hF, '0, "read_forwarded");
    drive_idle(3);
    issue_request(k_hit, 32'h0000_0040, 1'b0, 4'hF, '0, "read_after_write");

    issue_request(k_miss, 32'h0000_1080, 1'b1, 4'b1001, $urandom, "write_miss");
    issue_request(k_hit, 32'h0000_1080, 1'b0, 4'hF, '0, "read_write_miss");

    issue_request(k_io, 32'hF000_0100, 1'b0, 4'hF, '0, "io_read");
    issue_request(k_io, 32'hF000_0100, 1'b1, 4'hF, $urandom, "io_write");
    issue_request(k_io, 32'hF000_0100, 1'b0, 4'b0011, '0, "io_read_back");
    drive_idle(2);

    fill_and_reread_set();
    drive_idle(4);

    $display("Summary: %0d requests, %0d cycles, %0d errors", n_requests, cycles, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
hdl/cache_pkg.sv
hdl/cache_tag_ram.sv
hdl/cache_data_ram.sv
hdl/cache_readable_ram.sv
hdl/cache_cmd_fsm.sv
hdl/cache_rw.sv
bench/cache_rw_clock.sv
bench/cache_rw_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the cache front end

VERILATOR ?= verilator
TOP       ?= cache_rw_tb
RTL_TOP   ?= cache_rw
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed
FAIL_MSG  ?= Testbench failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
